// ==== Makefile ====
# Verilator build and run for the host command AXI master

VERILATOR ?= verilator
TOP       ?= tb_axi_cmd_master
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_TEXT ?= TESTBENCH PASSED

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/axi_slave_model.sv ====
/*
  AXI memory slave model
  64 words, word addressed, one burst at a time.
  Stall holds every ready and valid output low
*/
module axi_slave_model (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   i_stall,
  input  axi_bus_pkg::axi_aw_t   i_aw,
  input  logic                   i_awvalid,
  output logic                   o_awready,
  input  axi_bus_pkg::axi_w_t    i_w,
  input  logic                   i_wvalid,
  output logic                   o_wready,
  output axi_bus_pkg::axi_resp_e o_bresp,
  output logic                   o_bvalid,
  input  logic                   i_bready,
  input  axi_bus_pkg::axi_ar_t   i_ar,
  input  logic                   i_arvalid,
  output logic                   o_arready,
  output axi_bus_pkg::axi_r_t    o_r,
  output logic                   o_rvalid,
  input  logic                   i_rready
);
  import axi_bus_pkg::*;

  typedef enum logic [1:0] {S_IDLE, S_W, S_B, S_R} state_e;

  state_e      state;
  logic [31:0] mem [64];
  logic [31:0] addr;
  logic [3:0]  len;
  logic [3:0]  beat;
  axi_burst_e  burst;
  logic        active;

  assign active    = !rst && !i_stall;
  assign o_awready = active && (state == S_IDLE);
  assign o_arready = active && (state == S_IDLE) && !i_awvalid;  // Writes first
  assign o_wready  = active && (state == S_W);
  assign o_bvalid  = active && (state == S_B);
  assign o_bresp   = RESP_OKAY;
  assign o_rvalid  = active && (state == S_R);
  assign o_r       = '{data: mem[addr[5:0]], resp: RESP_OKAY, last: (beat == len)};

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= S_IDLE;
      beat  <= '0;
    end else begin
      case (state)
        S_IDLE: begin
          beat <= '0;
          if (o_awready && i_awvalid) begin
            addr  <= i_aw.addr;
            len   <= i_aw.len;
            burst <= i_aw.burst;
            state <= S_W;
          end else if (o_arready && i_arvalid) begin
            addr  <= i_ar.addr;
            len   <= i_ar.len;
            burst <= i_ar.burst;
            state <= S_R;
          end
        end
        S_W: begin
          if (o_wready && i_wvalid) begin
            // Byte lanes follow the write strobe
            for (int b = 0; b < 4; b++) begin
              if (i_w.strb[b]) mem[addr[5:0]][8*b +: 8] <= i_w.data[8*b +: 8];
            end
            if (burst == BURST_INCR) addr <= addr + 32'd1;  // One word per beat
            if (i_w.last) state <= S_B;
          end
        end
        S_B: if (o_bvalid && i_bready) state <= S_IDLE;
        default: begin
          if (o_rvalid && i_rready) begin
            if (burst == BURST_INCR) addr <= addr + 32'd1;
            beat <= beat + 4'd1;
            if (beat == len) state <= S_IDLE;
          end
        end
      endcase
    end
  end

endmodule

// ==== bench/tb_axi_cmd_master.sv ====
/*
  Testbench for the host command AXI master
  Sends commands over the ingress link, answers the egress link
  and checks status words, read data and slave memory
*/
module tb_axi_cmd_master;
  import host_cmd_pkg::*;
  import axi_bus_pkg::*;

  localparam int WAIT_LIMIT    = 200;  // Cycles per handshake phase
  localparam int SILENCE_LIMIT = 40;

  // Status bits as the host sees them, bus response in 9:8
  localparam host_word_t ST_CMPLT  = 32'h0000_0001;
  localparam host_word_t ST_PING   = 32'h0000_0002;
  localparam host_word_t ST_WRITE  = 32'h0000_0004;
  localparam host_word_t ST_READ   = 32'h0000_0008;
  localparam host_word_t ST_CFG_WR = 32'h0000_0010;
  localparam host_word_t ST_CFG_RD = 32'h0000_0020;
  localparam host_word_t ST_UNREC  = 32'h0000_0040;
  localparam host_word_t ST_NACK   = 32'h0000_0080;

  logic       clk;
  logic       rst;
  logic       in_req;
  host_word_t in_data;
  logic       in_ack;
  logic       out_req;
  host_word_t out_data;
  logic       out_ack;
  logic       stall;
  axi_aw_t    aw;
  logic       awvalid;
  logic       awready;
  axi_w_t     w;
  logic       wvalid;
  logic       wready;
  axi_resp_e  bresp;
  logic       bvalid;
  logic       bready;
  axi_ar_t    ar;
  logic       arvalid;
  logic       arready;
  axi_r_t     r;
  logic       rvalid;
  logic       rready;

  string      cur_test;
  int         errors;
  int         errors_at_start;
  int         tests_run;
  int         tests_failed;
  host_word_t wr_data [$];  // Incrementing burst, read back later
  axi_aw_t    aw_seen;      // Last accepted write address

  axi_cmd_master dut_i (
    .clk (clk), .rst (rst),
    .i_in_req (in_req), .i_in_data (in_data), .o_in_ack (in_ack),
    .o_out_req (out_req), .o_out_data (out_data), .i_out_ack (out_ack),
    .o_aw (aw), .o_awvalid (awvalid), .i_awready (awready),
    .o_w (w), .o_wvalid (wvalid), .i_wready (wready),
    .i_bresp (bresp), .i_bvalid (bvalid), .o_bready (bready),
    .o_ar (ar), .o_arvalid (arvalid), .i_arready (arready),
    .i_r (r), .i_rvalid (rvalid), .o_rready (rready)
  );

  axi_slave_model slave_i (
    .clk (clk), .rst (rst), .i_stall (stall),
    .i_aw (aw), .i_awvalid (awvalid), .o_awready (awready),
    .i_w (w), .i_wvalid (wvalid), .o_wready (wready),
    .o_bresp (bresp), .o_bvalid (bvalid), .i_bready (bready),
    .i_ar (ar), .i_arvalid (arvalid), .o_arready (arready),
    .o_r (r), .o_rvalid (rvalid), .i_rready (rready)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    if (awvalid && awready) aw_seen <= aw;
  end

  function automatic host_word_t hdr_word(input logic [15:0] opcode, input bit mcfg,
                                          input bit incr);
    return {14'd0, incr, mcfg, opcode};
  endfunction

  task automatic check_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("ERROR %s: %s expected %h actual %h", cur_test, what, exp, act);
      errors++;
    end
  endtask

  task automatic note_failure(input string msg);
    $display("%s: %s", cur_test, msg);
    errors++;
  endtask

  task automatic check_mem(input logic [5:0] addr, input host_word_t exp);
    check_eq($sformatf("slave word %0d", addr), exp, slave_i.mem[addr]);
  endtask

  // One word over the four-phase ingress link
  task automatic send_word(input host_word_t word);
    int n;
    @(posedge clk);
    in_data <= word;
    in_req  <= 1'b1;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!in_ack && n < WAIT_LIMIT);
    if (!in_ack) note_failure("ingress ack never rose");
    in_req <= 1'b0;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (in_ack && n < WAIT_LIMIT);
    if (in_ack) note_failure("ingress ack never fell");
  endtask

  task automatic send_header(input host_word_t word0, input host_word_t count,
                             input host_word_t addr);
    send_word(word0);
    send_word(count);
    send_word(addr);
  endtask

  // Got stays low when no req shows up within the limit
  task automatic recv_word(input int limit, output host_word_t word, output bit got);
    int n;
    word = '0;
    got  = 1'b0;
    n    = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!out_req && n < limit);
    if (out_req) begin
      word = out_data;
      got  = 1'b1;
      out_ack <= 1'b1;
      n = 0;
      do begin
        @(posedge clk);
        n++;
      end while (out_req && n < WAIT_LIMIT);
      if (out_req) note_failure("egress req never fell");
      out_ack <= 1'b0;
    end
  endtask

  task automatic expect_word(input string what, input host_word_t exp);
    host_word_t word;
    bit         got;
    recv_word(WAIT_LIMIT, word, got);
    if (!got) note_failure({"no response word for ", what});
    else check_eq(what, exp, word);
  endtask

  task automatic expect_silence(input string what);
    host_word_t word;
    bit         got;
    recv_word(SILENCE_LIMIT, word, got);
    if (got) note_failure({"unexpected response word after ", what});
  endtask

  task automatic begin_test(input string name);
    cur_test        = name;
    errors_at_start = errors;
  endtask

  task automatic end_test();
    tests_run++;
    if (errors == errors_at_start) begin
      $display("test %s: ok", cur_test);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", cur_test, errors - errors_at_start);
    end
  endtask

  task automatic test_ping();
    begin_test("ping");
    send_header(hdr_word(16'd0, 1'b0, 1'b0), 32'd0, 32'd0);
    expect_word("status", ST_CMPLT | ST_PING);
    expect_silence("status");
    end_test();
  endtask

  task automatic test_axi_write();
    int         i;
    host_word_t word;
    begin_test("axi_write");
    wr_data.delete();
    send_header(hdr_word(16'd1, 1'b0, 1'b1), 32'd4, 32'd8);
    for (i = 0; i < 4; i++) begin
      wr_data.push_back($urandom);
      send_word(wr_data[i]);
    end
    expect_word("incr status", ST_CMPLT | ST_WRITE);
    check_eq("incr aw len", 32'd3, 32'(aw_seen.len));
    check_eq("incr aw burst", 32'd1, 32'(aw_seen.burst));
    for (i = 0; i < 4; i++) check_mem(6'(8 + i), wr_data[i]);
    // Fixed burst lands every beat on word 20
    send_header(hdr_word(16'd1, 1'b0, 1'b0), 32'd3, 32'd20);
    word = '0;
    for (i = 0; i < 3; i++) begin
      word = $urandom;
      send_word(word);
    end
    expect_word("fixed status", ST_CMPLT | ST_WRITE);
    check_eq("fixed aw len", 32'd2, 32'(aw_seen.len));
    check_eq("fixed aw burst", 32'd0, 32'(aw_seen.burst));
    check_mem(6'd20, word);
    end_test();
  endtask

  task automatic test_axi_read();
    int i;
    begin_test("axi_read");
    send_header(hdr_word(16'd2, 1'b0, 1'b1), 32'd4, 32'd8);
    expect_word("status", ST_CMPLT | ST_READ);
    for (i = 0; i < 4; i++) expect_word($sformatf("data %0d", i), wr_data[i]);
    expect_silence("last data word");
    end_test();
  endtask

  task automatic test_config();
    begin_test("config");
    send_header(hdr_word(16'd1, 1'b1, 1'b0), 32'd2, 32'd0);
    send_word(32'd0);   // Write response and NACK off
    send_word(32'd50);  // Timeout
    expect_silence("config write");
    send_header(hdr_word(16'd2, 1'b1, 1'b0), 32'd2, 32'd0);
    expect_word("status", ST_CMPLT | ST_CFG_RD);
    expect_word("flags", 32'd0);
    expect_word("timeout", 32'd50);
    send_header(hdr_word(16'd2, 1'b1, 1'b0), 32'd1, 32'd3);
    expect_word("unmapped status", ST_CMPLT | ST_CFG_RD);
    expect_word("unmapped value", 32'd0);
    end_test();
  endtask

  task automatic test_nack();
    begin_test("nack");
    send_header(hdr_word(16'd1, 1'b1, 1'b0), 32'd2, 32'd0);
    send_word(32'd3);
    send_word(32'd20);
    expect_word("config write status", ST_CMPLT | ST_CFG_WR);
    stall <= 1'b1;  // Slave never answers the read address
    send_header(hdr_word(16'd2, 1'b0, 1'b1), 32'd4, 32'd8);
    expect_word("status", ST_CMPLT | ST_READ | ST_NACK);
    expect_silence("nack status");
    stall <= 1'b0;
    end_test();
  endtask

  task automatic test_reject();
    begin_test("reject");
    send_header(hdr_word(16'd7, 1'b0, 1'b0), 32'd1, 32'd0);
    expect_word("unknown opcode status", ST_CMPLT | ST_UNREC);
    expect_silence("unknown opcode status");
    send_header(hdr_word(16'd2, 1'b0, 1'b0), 32'd0, 32'd0);
    expect_word("zero count status", ST_CMPLT | ST_UNREC);
    end_test();
  endtask

  initial begin
    rst          = 1'b1;
    in_req       = 1'b0;
    in_data      = '0;
    out_ack      = 1'b0;
    stall        = 1'b0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    void'($urandom(32'he0c8));
    repeat (8) @(posedge clk);
    rst <= 1'b0;

    test_ping();
    test_axi_write();
    test_axi_read();
    test_config();
    test_nack();
    test_reject();

    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// ==== build.f ====
design/host_cmd_pkg.sv
design/axi_bus_pkg.sv
design/cmd_decode.sv
design/axi_execute.sv
design/cmd_result.sv
design/axi_cmd_master.sv
bench/axi_slave_model.sv
bench/tb_axi_cmd_master.sv

// ==== design/axi_bus_pkg.sv ====
/*
  AXI channel payloads
  Address, write data and read data structs with
  burst and response codes, 32-bit data only
*/
package axi_bus_pkg;

  typedef enum logic [1:0] {
    BURST_FIXED = 2'd0,
    BURST_INCR  = 2'd1
  } axi_burst_e;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'd0,
    RESP_EXOKAY = 2'd1,
    RESP_SLVERR = 2'd2,
    RESP_DECERR = 2'd3
  } axi_resp_e;

  // Same layout on both address channels
  typedef struct packed {
    logic [31:0] addr;
    logic [3:0]  len;    // Beats minus one
    axi_burst_e  burst;
  } axi_ax_t;

  typedef axi_ax_t axi_aw_t;
  typedef axi_ax_t axi_ar_t;

  typedef struct packed {
    logic [31:0] data;
    logic [3:0]  strb;
    logic        last;
  } axi_w_t;

  typedef struct packed {
    logic [31:0] data;
    axi_resp_e   resp;
    logic        last;
  } axi_r_t;

endpackage

// ==== design/axi_cmd_master.sv ====
/*
  Host command AXI master
  Decode, execute and result stages between the
  four-phase host links and a single AXI master port
*/
module axi_cmd_master #(
  parameter bit          RST_WR_RESP = 1'b1,
  parameter logic [31:0] RST_TIMEOUT = 32'd1000
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     i_in_req,
  input  host_cmd_pkg::host_word_t i_in_data,
  output logic                     o_in_ack,
  output logic                     o_out_req,
  output host_cmd_pkg::host_word_t o_out_data,
  input  logic                     i_out_ack,
  output axi_bus_pkg::axi_aw_t     o_aw,
  output logic                     o_awvalid,
  input  logic                     i_awready,
  output axi_bus_pkg::axi_w_t      o_w,
  output logic                     o_wvalid,
  input  logic                     i_wready,
  input  axi_bus_pkg::axi_resp_e   i_bresp,
  input  logic                     i_bvalid,
  output logic                     o_bready,
  output axi_bus_pkg::axi_ar_t     o_ar,
  output logic                     o_arvalid,
  input  logic                     i_arready,
  input  axi_bus_pkg::axi_r_t      i_r,
  input  logic                     i_rvalid,
  output logic                     o_rready
);
  import host_cmd_pkg::*;

  cmd_t       cmd;
  logic       cmd_valid;
  logic       cmd_done;
  host_word_t pay_data;
  logic       pay_valid;
  logic       pay_take;
  logic       rd_push;
  host_word_t rd_data;
  logic       fin;
  status_t    fin_status;
  logic       fin_resp_en;

  cmd_decode decode_i (
    .clk         (clk),
    .rst         (rst),
    .i_in_req    (i_in_req),
    .i_in_data   (i_in_data),
    .o_in_ack    (o_in_ack),
    .o_cmd       (cmd),
    .o_cmd_valid (cmd_valid),
    .i_cmd_done  (cmd_done),
    .o_pay_data  (pay_data),
    .o_pay_valid (pay_valid),
    .i_pay_take  (pay_take)
  );

  axi_execute #(
    .RST_WR_RESP (RST_WR_RESP),
    .RST_TIMEOUT (RST_TIMEOUT)
  ) execute_i (
    .clk           (clk),
    .rst           (rst),
    .i_cmd         (cmd),
    .i_cmd_valid   (cmd_valid),
    .o_cmd_done    (cmd_done),
    .i_pay_data    (pay_data),
    .i_pay_valid   (pay_valid),
    .o_pay_take    (pay_take),
    .o_aw          (o_aw),
    .o_awvalid     (o_awvalid),
    .i_awready     (i_awready),
    .o_w           (o_w),
    .o_wvalid      (o_wvalid),
    .i_wready      (i_wready),
    .i_bresp       (i_bresp),
    .i_bvalid      (i_bvalid),
    .o_bready      (o_bready),
    .o_ar          (o_ar),
    .o_arvalid     (o_arvalid),
    .i_arready     (i_arready),
    .i_r           (i_r),
    .i_rvalid      (i_rvalid),
    .o_rready      (o_rready),
    .o_rd_push     (rd_push),
    .o_rd_data     (rd_data),
    .o_fin         (fin),
    .o_fin_status  (fin_status),
    .o_fin_resp_en (fin_resp_en)
  );

  cmd_result result_i (
    .clk           (clk),
    .rst           (rst),
    .i_rd_push     (rd_push),
    .i_rd_data     (rd_data),
    .i_fin         (fin),
    .i_fin_status  (fin_status),
    .i_fin_resp_en (fin_resp_en),
    .o_out_req     (o_out_req),
    .o_out_data    (o_out_data),
    .i_out_ack     (i_out_ack)
  );

endmodule

// ==== design/axi_execute.sv ====
/*
  Command execution
  Sequences the AXI channels for bus reads and writes, holds the
  flags and timeout registers, bounds every wait when NACK is on
  and ends each command with a fin pulse and status word
*/
module axi_execute #(
  parameter bit          RST_WR_RESP = 1'b1,
  parameter logic [31:0] RST_TIMEOUT = 32'd1000
) (
  input  logic                     clk,
  input  logic                     rst,
  input  host_cmd_pkg::cmd_t       i_cmd,
  input  logic                     i_cmd_valid,
  output logic                     o_cmd_done,
  input  host_cmd_pkg::host_word_t i_pay_data,
  input  logic                     i_pay_valid,
  output logic                     o_pay_take,
  output axi_bus_pkg::axi_aw_t     o_aw,
  output logic                     o_awvalid,
  input  logic                     i_awready,
  output axi_bus_pkg::axi_w_t      o_w,
  output logic                     o_wvalid,
  input  logic                     i_wready,
  input  axi_bus_pkg::axi_resp_e   i_bresp,
  input  logic                     i_bvalid,
  output logic                     o_bready,
  output axi_bus_pkg::axi_ar_t     o_ar,
  output logic                     o_arvalid,
  input  logic                     i_arready,
  input  axi_bus_pkg::axi_r_t      i_r,
  input  logic                     i_rvalid,
  output logic                     o_rready,
  output logic                     o_rd_push,
  output host_cmd_pkg::host_word_t o_rd_data,
  output logic                     o_fin,
  output host_cmd_pkg::status_t    o_fin_status,
  output logic                     o_fin_resp_en
);
  import host_cmd_pkg::*;
  import axi_bus_pkg::*;

  typedef enum logic [3:0] {
    S_IDLE, S_AW, S_W, S_B, S_AR, S_R, S_CFG_WR, S_CFG_RD, S_FIN
  } state_e;

  state_e     state;
  logic [4:0] beat;
  logic [4:0] len_m1;
  logic       last_beat;
  axi_ax_t    ax;
  host_word_t cfg_addr;
  host_word_t cfg_rdata;
  logic       wr_resp_en;
  logic       nack_en;
  host_word_t timeout;
  host_word_t wait_cnt;
  logic       waiting;
  logic       progress;
  logic       time_up;
  logic       nack;
  axi_resp_e  bus_resp;

  assign len_m1    = i_cmd.count - 5'd1;
  assign last_beat = (beat == len_m1);

  assign ax.addr  = i_cmd.addr;
  assign ax.len   = len_m1[3:0];
  assign ax.burst = i_cmd.incr ? BURST_INCR : BURST_FIXED;
  assign o_aw     = ax;
  assign o_ar     = ax;

  assign o_w       = '{data: i_pay_data, strb: 4'hf, last: last_beat};
  assign o_awvalid = (state == S_AW);
  assign o_wvalid  = (state == S_W) && i_pay_valid;  // Follows the host pace
  assign o_bready  = (state == S_B);
  assign o_arvalid = (state == S_AR);
  assign o_rready  = (state == S_R);  // Result buffer fits a full burst

  assign o_pay_take = ((state == S_W) && i_wready) || (state == S_CFG_WR);
  assign o_rd_push  = ((state == S_R) && i_rvalid) || (state == S_CFG_RD);
  assign o_rd_data  = (state == S_R) ? i_r.data : cfg_rdata;

  assign waiting  = (state inside {S_AW, S_W, S_B, S_AR, S_R});
  assign progress = (o_awvalid && i_awready) || (o_wvalid && i_wready) ||
                    (o_bready && i_bvalid) || (o_arvalid && i_arready) ||
                    (o_rready && i_rvalid);
  assign time_up  = waiting && !progress && nack_en && (wait_cnt >= timeout);

  always_comb begin
    cfg_rdata = '0;  // Unmapped addresses read zero
    if (cfg_addr == CFG_FLAGS) begin
      cfg_rdata[CFG_FLAG_WR_RESP] = wr_resp_en;
      cfg_rdata[CFG_FLAG_NACK]    = nack_en;
    end else if (cfg_addr == CFG_TIMEOUT) begin
      cfg_rdata = timeout;
    end
  end

  assign o_fin      = (state == S_FIN);
  assign o_cmd_done = (state == S_FIN);

  always_comb begin
    o_fin_status        = '0;
    o_fin_status.cmplt  = 1'b1;
    o_fin_status.ping   = (i_cmd.kind == CMD_PING);
    o_fin_status.write  = (i_cmd.kind == CMD_AXI_WR);
    o_fin_status.read   = (i_cmd.kind == CMD_AXI_RD);
    o_fin_status.cfg_wr = (i_cmd.kind == CMD_CFG_WR);
    o_fin_status.cfg_rd = (i_cmd.kind == CMD_CFG_RD);
    o_fin_status.unrec  = (i_cmd.kind == CMD_REJECT);
    o_fin_status.nack   = nack;
    o_fin_status.bresp  = bus_resp;
    // Writes stay silent unless the write response is enabled
    o_fin_resp_en = wr_resp_en ||
                    !((i_cmd.kind == CMD_AXI_WR) || (i_cmd.kind == CMD_CFG_WR));
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= S_IDLE;
      beat       <= '0;
      cfg_addr   <= '0;
      nack       <= 1'b0;
      bus_resp   <= RESP_OKAY;
      wait_cnt   <= '0;
      wr_resp_en <= RST_WR_RESP;
      nack_en    <= 1'b0;
      timeout    <= RST_TIMEOUT;
    end else begin
      wait_cnt <= (!waiting || progress) ? '0 : wait_cnt + 32'd1;

      if (time_up) begin
        nack  <= 1'b1;
        state <= S_FIN;
      end else begin
        case (state)
          S_IDLE: begin
            if (i_cmd_valid) begin
              beat     <= '0;
              cfg_addr <= i_cmd.addr;
              nack     <= 1'b0;
              bus_resp <= RESP_OKAY;
              case (i_cmd.kind)
                CMD_AXI_WR: state <= S_AW;
                CMD_AXI_RD: state <= S_AR;
                CMD_CFG_WR: state <= S_CFG_WR;
                CMD_CFG_RD: state <= S_CFG_RD;
                default:    state <= S_FIN;  // Ping and reject
              endcase
            end
          end
          S_AW: if (i_awready) state <= S_W;
          S_W: begin
            if (o_wvalid && i_wready) begin
              beat <= beat + 5'd1;
              if (last_beat) begin
                state <= S_B;
              end
            end
          end
          S_B: begin
            if (i_bvalid) begin
              bus_resp <= i_bresp;
              state    <= S_FIN;
            end
          end
          S_AR: if (i_arready) state <= S_R;
          S_R: begin
            if (i_rvalid) begin
              bus_resp <= i_r.resp;
              if (i_r.last) begin
                state <= S_FIN;
              end
            end
          end
          S_CFG_WR: begin
            if (i_pay_valid) begin
              case (cfg_addr)
                CFG_FLAGS: begin
                  wr_resp_en <= i_pay_data[CFG_FLAG_WR_RESP];
                  nack_en    <= i_pay_data[CFG_FLAG_NACK];
                end
                CFG_TIMEOUT: timeout <= i_pay_data;
                default: ;
              endcase
              cfg_addr <= cfg_addr + 32'd1;
              beat     <= beat + 5'd1;
              if (last_beat) begin
                state <= S_FIN;
              end
            end
          end
          S_CFG_RD: begin
            cfg_addr <= cfg_addr + 32'd1;  // One register per cycle
            beat     <= beat + 5'd1;
            if (last_beat) begin
              state <= S_FIN;
            end
          end
          default: state <= S_IDLE;  // S_FIN lasts one cycle
        endcase
      end
    end
  end

endmodule

// ==== design/cmd_decode.sv ====
/*
  Command decode
  Four-phase ingress receiver. Collects the three header words,
  maps opcode and flags to a command kind and forwards write payload
*/
module cmd_decode (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     i_in_req,
  input  host_cmd_pkg::host_word_t i_in_data,
  output logic                     o_in_ack,
  output host_cmd_pkg::cmd_t       o_cmd,
  output logic                     o_cmd_valid,
  input  logic                     i_cmd_done,
  output host_cmd_pkg::host_word_t o_pay_data,
  output logic                     o_pay_valid,
  input  logic                     i_pay_take
);
  import host_cmd_pkg::*;

  host_word_t hdr_cmd;
  host_word_t hdr_count;
  logic [1:0] hdr_idx;
  host_word_t pay_left;   // Payload words still owed by the host
  logic       in_hdr;
  logic       can_take;
  logic       take;
  opcode_e    op;
  cmd_flags_t flags;
  logic       count_ok;
  cmd_kind_e  dec_kind;

  // Header only once the previous command and its payload are gone
  assign in_hdr   = !o_cmd_valid && (pay_left == '0);
  assign can_take = in_hdr || ((pay_left != '0) && !o_pay_valid);
  assign take     = i_in_req && !o_in_ack && can_take;

  assign op       = opcode_e'(hdr_cmd[15:0]);
  assign flags    = cmd_flags_t'(hdr_cmd[31:16]);
  assign count_ok = (hdr_count != '0) && (hdr_count <= MAX_BEATS);

  always_comb begin
    case (op)
      OP_PING:  dec_kind = CMD_PING;
      OP_WRITE: dec_kind = flags.mcfg ? CMD_CFG_WR : CMD_AXI_WR;
      OP_READ:  dec_kind = flags.mcfg ? CMD_CFG_RD : CMD_AXI_RD;
      default:  dec_kind = CMD_REJECT;
    endcase
    if (op != OP_PING && !count_ok) begin
      dec_kind = CMD_REJECT;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      o_in_ack    <= 1'b0;
      o_cmd_valid <= 1'b0;
      o_pay_valid <= 1'b0;
      hdr_idx     <= '0;
      pay_left    <= '0;
    end else begin
      if (take) begin
        o_in_ack <= 1'b1;
      end else if (o_in_ack && !i_in_req) begin
        o_in_ack <= 1'b0;
      end

      if (i_cmd_done) begin
        o_cmd_valid <= 1'b0;
      end
      if (i_cmd_done || (o_pay_valid && i_pay_take)) begin
        o_pay_valid <= 1'b0;
      end

      if (take && in_hdr) begin
        hdr_idx <= (hdr_idx == 2'd2) ? 2'd0 : hdr_idx + 2'd1;
        if (hdr_idx == 2'd2) begin
          o_cmd_valid <= 1'b1;
          // Rejected writes still drain their payload
          pay_left    <= (op == OP_WRITE) ? hdr_count : '0;
        end
      end else if (take) begin
        pay_left <= pay_left - 32'd1;
        if (o_cmd_valid && !i_cmd_done) begin
          o_pay_valid <= 1'b1;  // Else dropped
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take && in_hdr) begin
      if (hdr_idx == 2'd0) begin
        hdr_cmd <= i_in_data;
      end
      if (hdr_idx == 2'd1) begin
        hdr_count <= i_in_data;
      end
      if (hdr_idx == 2'd2) begin
        o_cmd <= '{kind: dec_kind, incr: flags.incr, count: hdr_count[4:0], addr: i_in_data};
      end
    end
    if (take && !in_hdr) begin
      o_pay_data <= i_in_data;
    end
  end

endmodule

// ==== design/cmd_result.sv ====
/*
  Command result
  Buffers read words of the current command and returns the
  status word plus data over the four-phase egress link
*/
module cmd_result (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     i_rd_push,
  input  host_cmd_pkg::host_word_t i_rd_data,
  input  logic                     i_fin,
  input  host_cmd_pkg::status_t    i_fin_status,
  input  logic                     i_fin_resp_en,
  output logic                     o_out_req,
  output host_cmd_pkg::host_word_t o_out_data,
  input  logic                     i_out_ack
);
  import host_cmd_pkg::*;

  typedef enum logic [1:0] {S_IDLE, S_REQ, S_DROP} state_e;

  state_e     state;
  host_word_t rd_buf [MAX_BEATS];
  logic [4:0] wr_cnt;
  logic [4:0] send_idx;   // 0 is the status word
  logic [4:0] send_last;
  logic [4:0] rd_idx;
  status_t    status_q;

  assign rd_idx     = send_idx - 5'd1;
  assign o_out_req  = (state == S_REQ);
  assign o_out_data = (send_idx == '0) ? host_word_t'(status_q) : rd_buf[rd_idx[3:0]];

  always_ff @(posedge clk) begin
    if (i_rd_push) begin
      rd_buf[wr_cnt[3:0]] <= i_rd_data;
    end
    if (i_fin) begin
      status_q <= i_fin_status;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= S_IDLE;
      wr_cnt    <= '0;
      send_idx  <= '0;
      send_last <= '0;
    end else begin
      if (i_rd_push) begin
        wr_cnt <= wr_cnt + 5'd1;
      end
      case (state)
        S_IDLE: begin
          if (i_fin) begin
            if (i_fin_resp_en) begin
              send_idx  <= '0;
              send_last <= i_fin_status.nack ? 5'd0 : wr_cnt;  // NACK drops data
              state     <= S_REQ;
            end else begin
              wr_cnt <= '0;
            end
          end
        end
        S_REQ: if (i_out_ack) state <= S_DROP;
        S_DROP: begin
          if (!i_out_ack) begin
            if (send_idx == send_last) begin
              wr_cnt <= '0;
              state  <= S_IDLE;
            end else begin
              send_idx <= send_idx + 5'd1;
              state    <= S_REQ;
            end
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

endmodule

// ==== design/host_cmd_pkg.sv ====
/*
  Host command types
  Link word, command header fields, decoded command,
  status word and master configuration addresses
*/
package host_cmd_pkg;

  localparam int unsigned MAX_BEATS = 16;

  typedef logic [31:0] host_word_t;

  // Low half of header word 0
  typedef enum logic [15:0] {
    OP_PING  = 16'd0,
    OP_WRITE = 16'd1,
    OP_READ  = 16'd2
  } opcode_e;

  // High half of header word 0
  typedef struct packed {
    logic [13:0] rsvd;
    logic        incr;  // Incrementing burst, fixed when clear
    logic        mcfg;  // Master configuration space
  } cmd_flags_t;

  typedef enum logic [2:0] {
    CMD_PING,
    CMD_AXI_WR,
    CMD_AXI_RD,
    CMD_CFG_WR,
    CMD_CFG_RD,
    CMD_REJECT
  } cmd_kind_e;

  typedef struct packed {
    cmd_kind_e   kind;
    logic        incr;
    logic [4:0]  count;  // 1 to 16 for bus and config kinds
    logic [31:0] addr;
  } cmd_t;

  // Sent back first on every response
  typedef struct packed {
    logic [21:0] rsvd;
    logic [1:0]  bresp;
    logic        nack;
    logic        unrec;
    logic        cfg_rd;
    logic        cfg_wr;
    logic        read;
    logic        write;
    logic        ping;
    logic        cmplt;
  } status_t;

  typedef enum logic [31:0] {
    CFG_FLAGS   = 32'd0,
    CFG_TIMEOUT = 32'd1
  } cfg_addr_e;

  // Bit positions in the flags register
  localparam int CFG_FLAG_WR_RESP = 0;
  localparam int CFG_FLAG_NACK    = 1;

endpackage
